// ==== hdl/lockstep_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared widths and types for the lockstep checker.
// Holds the opcode set of the accumulator core, the multi-bit enable
// encoding and the packed input and output bundles of a core.
//////////////////////////////////////////////////////////////////////

package lockstep_pkg;

  // Operand, accumulator and opcode widths
  parameter int unsigned DataWidth = 32;
  parameter int unsigned OpWidth   = 3;

  // Shadow core trails the main core by this many cycles
  parameter int unsigned DefaultOffset = 2;

  // Legal opcodes, remaining four encodings are illegal
  typedef enum logic [OpWidth-1:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_XOR  = 3'd2,
    OP_LOAD = 3'd3
  } opcode_e;

  // Multi-bit enable, anything but MUBI_OFF reads as enabled
  typedef enum logic [3:0] {
    MUBI_ON  = 4'h6,
    MUBI_OFF = 4'h9
  } mubi_e;

  // Inputs seen by both cores, opcode kept raw so illegal values pass
  typedef struct packed {
    logic                 instr_valid;
    logic [OpWidth-1:0]   opcode;
    logic [DataWidth-1:0] operand;
  } core_in_t;

  // Outputs compared between main and shadow
  typedef struct packed {
    logic                 result_valid;
    logic [DataWidth-1:0] result;
    opcode_e              last_op;
  } core_out_t;

endpackage

// ==== hdl/core_out_if.sv ====
//////////////////////////////////////////////////////////////////////
// Output bundle of the shadow core, carried to the comparator.
// The core drives every signal, the comparator only samples them.
//////////////////////////////////////////////////////////////////////

interface core_out_if;

  // One-cycle strobe per retired instruction
  logic                                result_valid;
  // Accumulator value
  logic [lockstep_pkg::DataWidth-1:0]  result;
  // Opcode of the last legal instruction
  lockstep_pkg::opcode_e               last_op;
  // One-cycle pulse on an illegal opcode
  logic                                major_alert;

  modport core (
    output result_valid, result, last_op, major_alert
  );

  modport check (
    input result_valid, result, last_op, major_alert
  );

endinterface

// ==== hdl/lockstep_rst_seq.sv ====
//////////////////////////////////////////////////////////////////////
// Post-reset sequencer for the shadow core.
// Keeps the shadow in reset for LockstepOffset edges after release,
// then turns the multi-bit compare enable on one edge later.
//////////////////////////////////////////////////////////////////////

module lockstep_rst_seq #(
  parameter int unsigned LockstepOffset = lockstep_pkg::DefaultOffset
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  output logic                shadow_rst_n_o,
  output lockstep_pkg::mubi_e enable_cmp_o
);

  import lockstep_pkg::*;

  // Wide enough to hold LockstepOffset itself
  localparam int unsigned CntWidth = $clog2(LockstepOffset + 1);

  logic [CntWidth-1:0] cnt_q;
  logic                shadow_set_q;
  mubi_e               enable_cmp_q;

  // Saturating post-reset counter
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_q < CntWidth'(LockstepOffset)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Release lands on the LockstepOffset-th edge after reset goes away
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shadow_set_q <= 1'b0;
    end else if (cnt_q >= CntWidth'(LockstepOffset - 1)) begin
      shadow_set_q <= 1'b1;
    end
  end

  // Comparison starts one edge behind the shadow release
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_cmp_q <= MUBI_OFF;
    end else begin
      enable_cmp_q <= shadow_set_q ? MUBI_ON : MUBI_OFF;
    end
  end

  assign shadow_rst_n_o = shadow_set_q;
  assign enable_cmp_o   = enable_cmp_q;

endmodule

// ==== hdl/lockstep_delay_line.sv ====
//////////////////////////////////////////////////////////////////////
// Fixed-length shift register for a packed bundle.
// data_o is data_i as it was Depth cycles earlier. Depth must be at
// least 1. Used on both the input and the main-output paths.
//////////////////////////////////////////////////////////////////////

module lockstep_delay_line #(
  parameter int unsigned Width = 1,
  parameter int unsigned Depth = 1
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o
);

  // Stage 0 takes the input, last stage feeds the output
  logic [Depth-1:0][Width-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= data_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[Depth-1];

endmodule

// ==== hdl/shadow_core.sv ====
//////////////////////////////////////////////////////////////////////
// Accumulator execution unit run as the delayed shadow copy.
// Each valid legal instruction updates the accumulator and raises a
// one-cycle result strobe. An illegal opcode raises the major alert
// instead and leaves the architectural state alone.
//////////////////////////////////////////////////////////////////////

module shadow_core (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  lockstep_pkg::core_in_t in_i,
  core_out_if.core               out
);

  import lockstep_pkg::*;

  logic [DataWidth-1:0] acc_d, acc_q;
  logic                 op_legal;
  opcode_e              last_op_q;
  logic                 valid_q;
  logic                 alert_q;

  //////////////////////////////////////////////////////////////////////
  // Decode and next accumulator value
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    op_legal = 1'b1;
    acc_d    = acc_q;
    case (in_i.opcode)
      OP_ADD:  acc_d = acc_q + in_i.operand;
      OP_SUB:  acc_d = acc_q - in_i.operand;
      OP_XOR:  acc_d = acc_q ^ in_i.operand;
      OP_LOAD: acc_d = in_i.operand;
      default: op_legal = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Architectural state and output strobes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q     <= '0;
      last_op_q <= OP_LOAD;
      valid_q   <= 1'b0;
      alert_q   <= 1'b0;
    end else begin
      valid_q <= in_i.instr_valid & op_legal;
      alert_q <= in_i.instr_valid & ~op_legal;
      if (in_i.instr_valid && op_legal) begin
        acc_q     <= acc_d;
        last_op_q <= opcode_e'(in_i.opcode);
      end
    end
  end

  assign out.result_valid = valid_q;
  assign out.result       = acc_q;
  assign out.last_op      = last_op_q;
  assign out.major_alert  = alert_q;

endmodule

// ==== hdl/lockstep_compare.sv ====
//////////////////////////////////////////////////////////////////////
// Lockstep comparator.
// Registers the shadow outputs once and checks them against the
// delayed main-core outputs while the compare enable is on.
//////////////////////////////////////////////////////////////////////

module lockstep_compare (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  lockstep_pkg::mubi_e     enable_cmp_i,
  core_out_if.check               shadow,
  input  lockstep_pkg::core_out_t main_delayed_i,
  output logic                    alert_major_o
);

  import lockstep_pkg::*;

  core_out_t shadow_d, shadow_q;
  logic      shadow_alert_q;
  logic      mismatch;

  assign shadow_d.result_valid = shadow.result_valid;
  assign shadow_d.result       = shadow.result;
  assign shadow_d.last_op      = shadow.last_op;

  // Extra stage lines the shadow up with main outputs delayed by offset+1
  always_ff @(posedge clk_i) begin
    shadow_q <= shadow_d;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shadow_alert_q <= 1'b0;
    end else begin
      shadow_alert_q <= shadow.major_alert;
    end
  end

  // Whole bundle compared, so every field counts
  assign mismatch = (shadow_q != main_delayed_i);

  // Both sources gated by the enable
  assign alert_major_o = (enable_cmp_i != MUBI_OFF) & (mismatch | shadow_alert_q);

endmodule

// ==== hdl/lockstep_top.sv ====
//////////////////////////////////////////////////////////////////////
// Top level of the dual-core lockstep checker.
// Takes the inputs given to the main core and the main core outputs,
// replays the inputs into a shadow core LockstepOffset cycles later
// and raises alert_major_o on any difference.
//////////////////////////////////////////////////////////////////////

module lockstep_top #(
  // Must be 2 or more
  parameter int unsigned LockstepOffset = lockstep_pkg::DefaultOffset
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Inputs shared with the main core
  input  logic                                instr_valid_i,
  input  logic [lockstep_pkg::OpWidth-1:0]    opcode_i,
  input  logic [lockstep_pkg::DataWidth-1:0]  operand_i,
  // Main core outputs
  input  logic                                core_result_valid_i,
  input  logic [lockstep_pkg::DataWidth-1:0]  core_result_i,
  input  logic [lockstep_pkg::OpWidth-1:0]    core_last_op_i,
  output logic                                alert_major_o
);

  import lockstep_pkg::*;

  // Main outputs wait one more cycle for the shadow output register
  localparam int unsigned OutputsOffset = LockstepOffset + 1;

  logic      shadow_rst_n;
  mubi_e     enable_cmp;
  core_in_t  main_in, shadow_in;
  core_out_t main_out, main_out_delayed;

  core_out_if shadow_out_if ();

  //////////////////////////////////////////////////////////////////////
  // Bundle packing
  //////////////////////////////////////////////////////////////////////

  assign main_in.instr_valid = instr_valid_i;
  assign main_in.opcode      = opcode_i;
  assign main_in.operand     = operand_i;

  assign main_out.result_valid = core_result_valid_i;
  assign main_out.result       = core_result_i;
  assign main_out.last_op      = opcode_e'(core_last_op_i);

  lockstep_rst_seq #(
    .LockstepOffset (LockstepOffset)
  ) u_rst_seq (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .shadow_rst_n_o (shadow_rst_n),
    .enable_cmp_o   (enable_cmp)
  );

  lockstep_delay_line #(
    .Width ($bits(core_in_t)),
    .Depth (LockstepOffset)
  ) u_in_delay (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (main_in),
    .data_o  (shadow_in)
  );

  lockstep_delay_line #(
    .Width ($bits(core_out_t)),
    .Depth (OutputsOffset)
  ) u_out_delay (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (main_out),
    .data_o  (main_out_delayed)
  );

  shadow_core u_shadow_core (
    .clk_i   (clk_i),
    .rst_n_i (shadow_rst_n),
    .in_i    (shadow_in),
    .out     (shadow_out_if.core)
  );

  lockstep_compare u_compare (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .enable_cmp_i   (enable_cmp),
    .shadow         (shadow_out_if.check),
    .main_delayed_i (main_out_delayed),
    .alert_major_o  (alert_major_o)
  );

endmodule

// ==== dv/lockstep_props.sv ====
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the lockstep comparator.
// Bound into every lockstep_compare instance below.
//////////////////////////////////////////////////////////////////////

module lockstep_props (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input lockstep_pkg::mubi_e     enable_cmp_i,
  input lockstep_pkg::core_out_t shadow_d_i,
  input lockstep_pkg::core_out_t shadow_q_i,
  input logic                    alert_major_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import lockstep_pkg::*;

  // No alert may leave the checker while reset is held
  property alert_low_in_reset_p;
    @(posedge clk_i) !rst_n_i |-> !alert_major_i;
  endproperty

  // Alert implies an active compare enable
  property alert_needs_enable_p;
    @(posedge clk_i) alert_major_i |-> (enable_cmp_i != MUBI_OFF);
  endproperty

  // Output stage of the shadow bundle is a plain one-cycle delay
  property shadow_stage_p;
    @(posedge clk_i) disable iff (!rst_n_i)
      shadow_q_i == $past(shadow_d_i);
  endproperty

  alert_low_in_reset_a : assert property (alert_low_in_reset_p)
    else $error("major alert raised while reset is asserted");

  alert_needs_enable_a : assert property (alert_needs_enable_p)
    else $error("major alert raised while compare enable is off");

  shadow_stage_a : assert property (shadow_stage_p)
    else $error("registered shadow bundle differs from previous shadow outputs");

endmodule

bind lockstep_compare lockstep_props u_props (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .enable_cmp_i  (enable_cmp_i),
  .shadow_d_i    (shadow_d),
  .shadow_q_i    (shadow_q),
  .alert_major_i (alert_major_o)
);

// ==== dv/tb_lockstep.sv ====
//////////////////////////////////////////////////////////////////////
// Directed testbench for the lockstep checker.
// Models the main core, feeds its inputs and outputs to the DUT and
// checks alert_major_o against the expected lockstep timing.
//////////////////////////////////////////////////////////////////////

module tb_lockstep;

  timeunit 1ns;
  timeprecision 1ps;

  import lockstep_pkg::*;

  localparam int unsigned Offset      = DefaultOffset;
  localparam int unsigned StreamLen   = 60;
  localparam int unsigned CorruptStep = 5;
  localparam int unsigned CorruptLen  = 14;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 instr_valid_i;
  logic [OpWidth-1:0]   opcode_i;
  logic [DataWidth-1:0] operand_i;
  logic                 core_result_valid_i = 1'b0;
  logic [DataWidth-1:0] core_result_i       = '0;
  logic [OpWidth-1:0]   core_last_op_i      = OP_LOAD;
  logic                 alert_major_o;

  // Main-core model state and output corruption controls
  logic [DataWidth-1:0] model_acc;
  logic [OpWidth-1:0]   model_last_op;
  logic                 model_valid;
  logic [DataWidth-1:0] result_flip;
  logic [OpWidth-1:0]   op_flip;
  logic                 garbage_en;

  int unsigned errors;
  int unsigned checks;

  lockstep_top #(
    .LockstepOffset (Offset)
  ) i_lockstep_top (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .instr_valid_i       (instr_valid_i),
    .opcode_i            (opcode_i),
    .operand_i           (operand_i),
    .core_result_valid_i (core_result_valid_i),
    .core_result_i       (core_result_i),
    .core_last_op_i      (core_last_op_i),
    .alert_major_o       (alert_major_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic is_legal(input logic [OpWidth-1:0] op);
    return op inside {OP_ADD, OP_SUB, OP_XOR, OP_LOAD};
  endfunction

  // Accumulator update for one legal instruction
  function automatic logic [DataWidth-1:0] apply_rule(input logic [DataWidth-1:0] acc,
                                                      input logic [OpWidth-1:0]   op,
                                                      input logic [DataWidth-1:0] operand);
    case (op)
      OP_ADD:  return acc + operand;
      OP_SUB:  return acc - operand;
      OP_XOR:  return acc ^ operand;
      OP_LOAD: return operand;
      default: return acc;
    endcase
  endfunction

  function automatic logic [OpWidth-1:0] rand_legal_op();
    case ($urandom_range(3, 0))
      0:       return OP_ADD;
      1:       return OP_SUB;
      2:       return OP_XOR;
      default: return OP_LOAD;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Main-core model with outputs one cycle after the instruction
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      model_acc     = '0;
      model_last_op = OP_LOAD;
      model_valid   = 1'b0;
    end else begin
      model_valid = instr_valid_i && is_legal(opcode_i);
      if (model_valid) begin
        model_acc     = apply_rule(model_acc, opcode_i, operand_i);
        model_last_op = opcode_i;
      end
    end
    if (!rst_n_i && garbage_en) begin
      core_result_valid_i <= 1'($urandom());
      core_result_i       <= $urandom();
      core_last_op_i      <= OpWidth'($urandom());
    end else begin
      core_result_valid_i <= model_valid;
      core_result_i       <= model_acc ^ result_flip;
      core_last_op_i      <= model_last_op ^ op_flip;
    end
  end

  // Drives one clock of stimulus and returns at the falling edge where outputs are stable
  task automatic drive_step(input logic                 valid,
                            input logic [OpWidth-1:0]   op,
                            input logic [DataWidth-1:0] operand,
                            input logic [DataWidth-1:0] res_mask,
                            input logic [OpWidth-1:0]   op_mask);
    @(posedge clk_i);
    instr_valid_i <= valid;
    opcode_i      <= op;
    operand_i     <= operand;
    result_flip   <= res_mask;
    op_flip       <= op_mask;
    @(negedge clk_i);
  endtask

  task automatic check_value(input string test_name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("[ERROR] %s: expected %0h, actual %0h", test_name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic idle_after_reset();
    for (int n = 0; n < 20; n++) begin
      drive_step(1'b0, '0, '0, '0, '0);
      check_value("idle_after_reset", 32'd0, 32'(alert_major_o));
    end
  endtask

  task automatic stream_random_legal();
    logic [DataWidth-1:0] exp_acc;
    logic [OpWidth-1:0]   op;
    logic [OpWidth-1:0]   prev_op;
    logic [DataWidth-1:0] operand;
    exp_acc = '0;
    prev_op = OP_LOAD;
    for (int i = 0; i <= StreamLen; i++) begin
      op      = rand_legal_op();
      operand = $urandom();
      drive_step(1'b1 && (i < StreamLen), op, operand, '0, '0);
      // Outputs now reflect the instruction of the previous step
      if (i > 0) begin
        check_value("random_stream valid", 32'd1, 32'(core_result_valid_i));
        check_value("random_stream result", exp_acc, core_result_i);
        check_value("random_stream last_op", 32'(prev_op), 32'(core_last_op_i));
      end
      check_value("random_stream alert", 32'd0, 32'(alert_major_o));
      exp_acc = apply_rule(exp_acc, op, operand);
      prev_op = op;
    end
    repeat (Offset + 2) begin
      drive_step(1'b0, '0, '0, '0, '0);
      check_value("random_stream alert", 32'd0, 32'(alert_major_o));
    end
  endtask

  // Mask set at step c reaches the outputs at edge k = c+1, so the
  // alert shows in the cycle after edge k+Offset+1, at step c+Offset+2
  task automatic corrupt_one_output(input string test_name, input logic on_last_op);
    logic [DataWidth-1:0] res_mask;
    logic [OpWidth-1:0]   op_mask;
    res_mask = DataWidth'(1) << $urandom_range(DataWidth - 1, 0);
    op_mask  = OpWidth'(1) << $urandom_range(OpWidth - 1, 0);
    for (int n = 0; n < CorruptLen; n++) begin
      if (n == CorruptStep && on_last_op) begin
        drive_step(1'b1, rand_legal_op(), $urandom(), '0, op_mask);
      end else if (n == CorruptStep) begin
        drive_step(1'b1, rand_legal_op(), $urandom(), res_mask, '0);
      end else begin
        drive_step(1'b1, rand_legal_op(), $urandom(), '0, '0);
      end
      check_value(test_name, 32'(n == CorruptStep + Offset + 2), 32'(alert_major_o));
    end
  endtask

  task automatic inject_illegal_opcode();
    logic [DataWidth-1:0] load_val;
    int unsigned          pulses;
    load_val = $urandom();
    drive_step(1'b1, OP_LOAD, load_val, '0, '0);
    drive_step(1'b1, {1'b1, 2'($urandom_range(3, 0))}, $urandom(), '0, '0);
    drive_step(1'b0, '0, '0, '0, '0);
    check_value("illegal_opcode valid", 32'd0, 32'(core_result_valid_i));
    check_value("illegal_opcode result", load_val, core_result_i);
    check_value("illegal_opcode last_op", 32'(OP_LOAD), 32'(core_last_op_i));
    pulses = 0;
    for (int n = 0; n < 10; n++) begin
      if (alert_major_o) begin
        pulses++;
      end
      drive_step(1'b0, '0, '0, '0, '0);
    end
    checks++;
    assert (pulses != 0) else begin
      errors++;
      $display("illegal_opcode: no major alert within 10 cycles of the illegal opcode");
    end
    if (pulses != 0) begin
      check_value("illegal_opcode pulses", 32'd1, pulses);
    end
  endtask

  task automatic release_reset_window();
    @(posedge clk_i);
    rst_n_i    <= 1'b0;
    garbage_en <= 1'b1;
    for (int n = 0; n < 6; n++) begin
      drive_step(1'b0, '0, '0, '0, '0);
      check_value("reset_window in reset", 32'd0, 32'(alert_major_o));
    end
    // Model falls back to its reset values for the last reset cycle
    @(posedge clk_i);
    garbage_en <= 1'b0;
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int n = 0; n < 12; n++) begin
      drive_step(1'b0, '0, '0, '0, '0);
      check_value("reset_window release", 32'd0, 32'(alert_major_o));
    end
  endtask

  initial begin
    void'($urandom(91));
    errors        = 0;
    checks        = 0;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    opcode_i      = '0;
    operand_i     = '0;
    result_flip   = '0;
    op_flip       = '0;
    garbage_en    = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;

    idle_after_reset();
    stream_random_legal();
    corrupt_one_output("result_corruption", 1'b0);
    corrupt_one_output("last_op_corruption", 1'b1);
    inject_illegal_opcode();
    release_reset_window();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/lockstep_pkg.sv
hdl/core_out_if.sv
hdl/lockstep_rst_seq.sv
hdl/lockstep_delay_line.sv
hdl/shadow_core.sv
hdl/lockstep_compare.sv
hdl/lockstep_top.sv
dv/lockstep_props.sv
dv/tb_lockstep.sv

// ==== run.sh ====
#!/bin/sh
# Build the lockstep testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log
PASS_TEXT="Test completed successfully"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module tb_lockstep \
  -Mdir "$BUILD_DIR" -o sim_tb_lockstep
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb_lockstep" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "$PASS_TEXT" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
